// File: hdl/gb_map_pkg.sv
// cpu address map
package gb_map_pkg;

    typedef logic [15:0] addr_t;   // cpu address
    typedef logic [7:0]  data_t;   // cpu data byte

    // decoded bus target, one per peripheral register or ram
    typedef enum logic [2:0] {
        none,     // unmapped, reads open bus
        wram,     // c000-fdff incl. echo
        hram,     // ff80-fffe
        joy,
        sb,
        sc,
        if_reg,
        ie_reg
    } region_t;

    localparam int wram_addr_width = 13;   // 8 KiB
    localparam int hram_addr_width = 7;    // 127 bytes used

    // ----------------------------------------
    // register and region addresses
    // ----------------------------------------
    localparam addr_t joy_addr  = 16'hff00;
    localparam addr_t sb_addr   = 16'hff01;
    localparam addr_t sc_addr   = 16'hff02;
    localparam addr_t if_addr   = 16'hff0f;
    localparam addr_t ie_addr   = 16'hffff;
    localparam addr_t wram_base = 16'hc000;
    localparam addr_t echo_end  = 16'hfdff;   // last echo byte
    localparam addr_t hram_base = 16'hff80;

    localparam data_t open_bus = 8'hff;      // nothing drives the bus

endpackage

// File: hdl/gb_io_pkg.sv
// interrupt, joypad and serial definitions
package gb_io_pkg;

    typedef logic [4:0] irq_t;   // one bit per source

    // bit positions, lower number wins
    localparam int irq_vblank = 0;
    localparam int irq_lcd    = 1;
    localparam int irq_timer  = 2;
    localparam int irq_serial = 3;
    localparam int irq_joypad = 4;

    localparam int irq_vec_base = 'h40;   // rst vector of bit 0
    localparam int irq_vec_step = 8;
    localparam gb_map_pkg::data_t idle_vec = 8'h55;   // nothing pending

    // ----------------------------------------
    // serial timing
    // ----------------------------------------
    localparam int serial_bit_cycles = 512;   // 8192 Hz from cpu clock
    localparam int serial_bits       = 8;
    localparam int serial_div_width  = $clog2(serial_bit_cycles);
    localparam int serial_cnt_width  = $clog2(serial_bits + 1);
    localparam logic [serial_div_width-1:0] serial_div_max =
        serial_div_width'(serial_bit_cycles - 1);
    localparam logic [serial_cnt_width-1:0] serial_cnt_load =
        serial_cnt_width'(serial_bits);

    // ----------------------------------------
    // fixed bits of register reads
    // ----------------------------------------
    localparam gb_map_pkg::data_t if_pad  = 8'he0;   // 7..5 read 1
    localparam gb_map_pkg::data_t ie_pad  = 8'h00;   // 7..5 read 0
    localparam gb_map_pkg::data_t sc_pad  = 8'h7e;   // 6..1 read 1
    localparam gb_map_pkg::data_t joy_pad = 8'hc0;   // 7..6 read 1

endpackage

// File: hdl/gb_spram.sv
// single port ram
`timescale 1ns/1ns

module gb_spram #(
    parameter int addr_width = 8
) (
    input  logic                  clk_cpu,
    input  logic [addr_width-1:0] addr,
    input  logic                  wren,
    input  gb_map_pkg::data_t     data,
    output gb_map_pkg::data_t     q
);

    gb_map_pkg::data_t mem [2**addr_width];

    always_ff @(posedge clk_cpu) begin
        if (wren) begin
            mem[addr] <= data;
        end
        q <= mem[addr];   // old data on a write cycle
    end

endmodule

// File: hdl/gb_work_ram.sv
// work ram and high ram
`timescale 1ns/1ns

module gb_work_ram (
    input  logic              clk_cpu,
    input  gb_map_pkg::addr_t cpu_addr,
    input  gb_map_pkg::data_t cpu_do,
    input  logic              wram_wr,
    input  logic              hram_wr,
    output gb_map_pkg::data_t wram_q,
    output gb_map_pkg::data_t hram_q
);

    logic [gb_map_pkg::wram_addr_width-1:0] wram_addr;
    logic [gb_map_pkg::hram_addr_width-1:0] hram_addr;

    // echo e000-fdff drops bit 13 and lands on c000-ddff
    assign wram_addr = cpu_addr[gb_map_pkg::wram_addr_width-1:0];
    assign hram_addr = cpu_addr[gb_map_pkg::hram_addr_width-1:0];   // ff80 -> 0

    // ----------------------------------------
    // 8k work ram
    // ----------------------------------------
    gb_spram #(
        .addr_width (gb_map_pkg::wram_addr_width)
    ) wram (
        .clk_cpu (clk_cpu),
        .addr    (wram_addr),
        .wren    (wram_wr),
        .data    (cpu_do),
        .q       (wram_q)
    );

    // ----------------------------------------
    // high ram, ffff is ie and never reaches it
    // ----------------------------------------
    gb_spram #(
        .addr_width (gb_map_pkg::hram_addr_width)
    ) hram (
        .clk_cpu (clk_cpu),
        .addr    (hram_addr),
        .wren    (hram_wr),
        .data    (cpu_do),
        .q       (hram_q)
    );

endmodule

// File: hdl/gb_joypad.sv
// joypad select and input edges
`timescale 1ns/1ns

module gb_joypad (
    input  logic              clk_cpu,
    input  logic              reset,
    input  logic              joy_wr,
    input  gb_map_pkg::data_t cpu_do,
    input  logic [3:0]        joy_din,     // p10..p13, low active
    output logic [1:0]        joy_p54,
    output gb_map_pkg::data_t joy_q,
    output logic              joy_event
);

    logic [3:0] din_s1;   // sync stages
    logic [3:0] din_s2;
    logic [3:0] din_old;  // previous synced value

    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            joy_p54 <= 2'b11;   // no line selected
            din_s1  <= 4'hf;
            din_s2  <= 4'hf;
            din_old <= 4'hf;
        end else begin
            if (joy_wr) begin
                joy_p54 <= cpu_do[5:4];
            end
            din_s1  <= joy_din;
            din_s2  <= din_s1;
            din_old <= din_s2;
        end
    end

    // any line going 1 -> 0
    assign joy_event = |(din_old & ~din_s2);

    assign joy_q = gb_io_pkg::joy_pad | {2'b00, joy_p54, joy_din};

endmodule

// File: hdl/gb_serial.sv
// serial port, internal clock only
`timescale 1ns/1ns

module gb_serial (
    input  logic              clk_cpu,
    input  logic              reset,
    input  logic              sb_wr,
    input  logic              sc_wr,
    input  gb_map_pkg::data_t cpu_do,
    output gb_map_pkg::data_t sb_q,
    output gb_map_pkg::data_t sc_q,
    output logic              serial_irq,
    output logic              sc_int_clock
);

    logic                                    sc_start;   // sc bit 7
    logic [gb_io_pkg::serial_div_width-1:0]  clk_div;    // cycles left in bit
    logic [gb_io_pkg::serial_cnt_width-1:0]  bit_cnt;    // bits left
    gb_map_pkg::data_t                       sb_r;
    logic                                    xfer_run;
    logic                                    shift_tick;

    assign xfer_run   = sc_start & sc_int_clock & ~sc_wr;
    assign shift_tick = xfer_run && clk_div == '0 && bit_cnt != '0;

    // ----------------------------------------
    // control and bit timing
    // ----------------------------------------
    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            sc_start     <= 1'b0;
            sc_int_clock <= 1'b0;
            serial_irq   <= 1'b0;
            clk_div      <= gb_io_pkg::serial_div_max;
            bit_cnt      <= gb_io_pkg::serial_cnt_load;
        end else begin
            serial_irq <= 1'b0;
            if (sc_wr) begin
                sc_start     <= cpu_do[7];
                sc_int_clock <= cpu_do[0];
                if (cpu_do[7]) begin   // restart transfer
                    clk_div <= gb_io_pkg::serial_div_max;
                    bit_cnt <= gb_io_pkg::serial_cnt_load;
                end
            end else if (xfer_run) begin
                clk_div <= clk_div - 1'b1;   // wraps to max
                if (shift_tick) begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
                if (bit_cnt == '0) begin   // all bits out
                    serial_irq <= 1'b1;
                    sc_start   <= 1'b0;
                    clk_div    <= gb_io_pkg::serial_div_max;
                    bit_cnt    <= gb_io_pkg::serial_cnt_load;
                end
            end
        end
    end

    // data byte, ones come in as no partner drives the line
    always_ff @(posedge clk_cpu) begin
        if (sb_wr) begin
            sb_r <= cpu_do;
        end else if (shift_tick) begin
            sb_r <= {sb_r[6:0], 1'b1};
        end
    end

    assign sb_q = sb_r;
    assign sc_q = gb_io_pkg::sc_pad | {sc_start, 6'b000000, sc_int_clock};

endmodule

// File: hdl/gb_interrupts.sv
// interrupt flag and enable
`timescale 1ns/1ns

module gb_interrupts (
    input  logic              clk_cpu,
    input  logic              reset,
    input  logic              if_wr,
    input  logic              ie_wr,
    input  gb_map_pkg::data_t cpu_do,
    input  logic              vblank_evt,
    input  logic              lcd_evt,
    input  logic              timer_evt,
    input  logic              serial_irq,
    input  logic              joy_event,
    input  logic              irq_ack,     // held for the ack cycle
    output gb_map_pkg::data_t if_q,
    output gb_map_pkg::data_t ie_q,
    output gb_map_pkg::data_t irq_vec,
    output logic              irq_n
);

    gb_io_pkg::irq_t if_r;
    gb_io_pkg::irq_t ie_r;
    gb_io_pkg::irq_t src;
    gb_io_pkg::irq_t src_old;    // last cycle's sources
    gb_io_pkg::irq_t src_rise;
    gb_io_pkg::irq_t pending;    // flagged and enabled
    gb_io_pkg::irq_t ack_clr;
    logic            ack_old;
    logic            ack_end;

    always_comb begin
        src                        = '0;
        src[gb_io_pkg::irq_vblank] = vblank_evt;
        src[gb_io_pkg::irq_lcd]    = lcd_evt;
        src[gb_io_pkg::irq_timer]  = timer_evt;
        src[gb_io_pkg::irq_serial] = serial_irq;
        src[gb_io_pkg::irq_joypad] = joy_event;
    end

    assign src_rise = src & ~src_old;
    assign pending  = if_r & ie_r;
    assign ack_end  = ack_old & ~irq_ack;   // end of ack cycle
    // lowest set bit of pending
    assign ack_clr  = {5{ack_end}} & pending & (~pending + 5'd1);

    // ----------------------------------------
    // fixed priority vector
    // ----------------------------------------
    always_comb begin
        irq_vec = gb_io_pkg::idle_vec;
        for (int i = gb_io_pkg::irq_joypad; i >= 0; i--) begin
            if (pending[i]) begin   // lower bit overrides
                irq_vec = 8'(gb_io_pkg::irq_vec_base + gb_io_pkg::irq_vec_step * i);
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            if_r    <= '0;
            ie_r    <= '0;
            src_old <= '0;
            ack_old <= 1'b0;
            irq_n   <= 1'b1;
        end else begin
            src_old <= src;
            ack_old <= irq_ack;
            irq_n   <= ~|pending;
            if (if_wr) begin
                if_r <= cpu_do[4:0];   // cpu write replaces flags
            end else begin
                if_r <= (if_r & ~ack_clr) | src_rise;
            end
            if (ie_wr) begin
                ie_r <= cpu_do[4:0];
            end
        end
    end

    assign if_q = gb_io_pkg::if_pad | {3'b000, if_r};
    assign ie_q = gb_io_pkg::ie_pad | {3'b000, ie_r};

endmodule

// File: hdl/gb_cpu_bus.sv
// cpu bus decode and read mux
`timescale 1ns/1ns

module gb_cpu_bus (
    input  logic              clk_cpu,
    input  logic              reset,
    input  gb_map_pkg::addr_t cpu_addr,
    input  logic              cpu_wr,
    input  logic              cpu_rd,
    input  logic              irq_ack,
    output logic              wram_wr,
    output logic              hram_wr,
    output logic              joy_wr,
    output logic              sb_wr,
    output logic              sc_wr,
    output logic              if_wr,
    output logic              ie_wr,
    input  gb_map_pkg::data_t wram_q,
    input  gb_map_pkg::data_t hram_q,
    input  gb_map_pkg::data_t joy_q,
    input  gb_map_pkg::data_t sb_q,
    input  gb_map_pkg::data_t sc_q,
    input  gb_map_pkg::data_t if_q,
    input  gb_map_pkg::data_t ie_q,
    input  gb_map_pkg::data_t irq_vec,
    output gb_map_pkg::data_t cpu_di
);

    gb_map_pkg::region_t region;
    gb_map_pkg::region_t sel_q;     // region of last read
    logic                ack_q;     // last read was an ack
    logic                rd_valid;  // read data due this cycle
    gb_map_pkg::data_t   reg_byte;
    gb_map_pkg::data_t   reg_q;     // register byte, lined up with ram q
    gb_map_pkg::data_t   rd_byte;
    gb_map_pkg::data_t   hold_q;    // keeps cpu_di between reads

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    always_comb begin
        region = gb_map_pkg::none;
        if (cpu_addr >= gb_map_pkg::wram_base && cpu_addr <= gb_map_pkg::echo_end)
            region = gb_map_pkg::wram;
        else if (cpu_addr == gb_map_pkg::ie_addr)
            region = gb_map_pkg::ie_reg;
        else if (cpu_addr >= gb_map_pkg::hram_base)
            region = gb_map_pkg::hram;
        else if (cpu_addr == gb_map_pkg::joy_addr)
            region = gb_map_pkg::joy;
        else if (cpu_addr == gb_map_pkg::sb_addr)
            region = gb_map_pkg::sb;
        else if (cpu_addr == gb_map_pkg::sc_addr)
            region = gb_map_pkg::sc;
        else if (cpu_addr == gb_map_pkg::if_addr)
            region = gb_map_pkg::if_reg;
    end

    assign wram_wr = cpu_wr && region == gb_map_pkg::wram;
    assign hram_wr = cpu_wr && region == gb_map_pkg::hram;
    assign joy_wr  = cpu_wr && region == gb_map_pkg::joy;
    assign sb_wr   = cpu_wr && region == gb_map_pkg::sb;
    assign sc_wr   = cpu_wr && region == gb_map_pkg::sc;
    assign if_wr   = cpu_wr && region == gb_map_pkg::if_reg;
    assign ie_wr   = cpu_wr && region == gb_map_pkg::ie_reg;

    // ----------------------------------------
    // read path
    // ----------------------------------------
    always_comb begin
        case (region)
            gb_map_pkg::joy:    reg_byte = joy_q;
            gb_map_pkg::sb:     reg_byte = sb_q;
            gb_map_pkg::sc:     reg_byte = sc_q;
            gb_map_pkg::if_reg: reg_byte = if_q;
            gb_map_pkg::ie_reg: reg_byte = ie_q;
            default:            reg_byte = gb_map_pkg::open_bus;
        endcase
        if (irq_ack) begin
            reg_byte = irq_vec;   // vector replaces the read
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            rd_valid <= 1'b0;
            ack_q    <= 1'b0;
            sel_q    <= gb_map_pkg::none;
            hold_q   <= gb_map_pkg::open_bus;
        end else begin
            rd_valid <= cpu_rd | irq_ack;
            if (cpu_rd | irq_ack) begin
                sel_q <= region;
                ack_q <= irq_ack;
            end
            if (rd_valid) begin
                hold_q <= rd_byte;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        reg_q <= reg_byte;   // same edge as the ram output register
    end

    always_comb begin
        if (ack_q)
            rd_byte = reg_q;
        else if (sel_q == gb_map_pkg::wram)
            rd_byte = wram_q;
        else if (sel_q == gb_map_pkg::hram)
            rd_byte = hram_q;
        else
            rd_byte = reg_q;
    end

    assign cpu_di = rd_valid ? rd_byte : hold_q;

endmodule

// File: hdl/gb_io_top.sv
// memory and io subsystem top
`timescale 1ns/1ns

module gb_io_top (
    input  logic              clk_cpu,
    input  logic              reset,
    input  gb_map_pkg::addr_t cpu_addr,
    input  gb_map_pkg::data_t cpu_do,
    input  logic              cpu_wr,
    input  logic              cpu_rd,
    input  logic              irq_ack,
    input  logic              vblank_evt,
    input  logic              lcd_evt,
    input  logic              timer_evt,
    input  logic [3:0]        joy_din,
    output gb_map_pkg::data_t cpu_di,
    output logic              irq_n,
    output logic [1:0]        joy_p54,
    output logic              sc_int_clock
);

    logic wram_wr, hram_wr, joy_wr, sb_wr, sc_wr, if_wr, ie_wr;   // write pulses
    gb_map_pkg::data_t wram_q, hram_q, joy_q, sb_q, sc_q, if_q, ie_q;
    gb_map_pkg::data_t irq_vec;
    logic serial_irq;
    logic joy_event;

    gb_cpu_bus bus (
        .clk_cpu, .reset, .cpu_addr, .cpu_wr, .cpu_rd, .irq_ack,
        .wram_wr, .hram_wr, .joy_wr, .sb_wr, .sc_wr, .if_wr, .ie_wr,
        .wram_q, .hram_q, .joy_q, .sb_q, .sc_q, .if_q, .ie_q, .irq_vec,
        .cpu_di
    );

    gb_work_ram ram (
        .clk_cpu, .cpu_addr, .cpu_do, .wram_wr, .hram_wr, .wram_q, .hram_q
    );

    gb_joypad joypad (
        .clk_cpu, .reset, .joy_wr, .cpu_do, .joy_din, .joy_p54, .joy_q, .joy_event
    );

    gb_serial serial (
        .clk_cpu, .reset, .sb_wr, .sc_wr, .cpu_do, .sb_q, .sc_q,
        .serial_irq, .sc_int_clock
    );

    gb_interrupts irq (
        .clk_cpu, .reset, .if_wr, .ie_wr, .cpu_do,
        .vblank_evt, .lcd_evt, .timer_evt, .serial_irq, .joy_event,
        .irq_ack, .if_q, .ie_q, .irq_vec, .irq_n
    );

endmodule

// File: tb/tb_gb_io.sv
// memory and io subsystem testbench
`timescale 1ns/1ns

module tb_gb_io;

    localparam int watchdog_cycles = 20000;
    // one transfer in reads, each read takes two clocks
    localparam int serial_reads =
        gb_io_pkg::serial_bits * gb_io_pkg::serial_bit_cycles / 2 + 50;

    logic              clk_cpu;
    logic              reset;
    gb_map_pkg::addr_t cpu_addr;
    gb_map_pkg::data_t cpu_do;
    logic              cpu_wr;
    logic              cpu_rd;
    logic              irq_ack;
    logic              vblank_evt;
    logic              lcd_evt;
    logic              timer_evt;
    logic [3:0]        joy_din;
    gb_map_pkg::data_t cpu_di;
    logic              irq_n;
    logic [1:0]        joy_p54;
    logic              sc_int_clock;

    integer seed = 32'hcd9a;
    int     errors;          // all tests
    int     test_errs;       // current test
    int     tests_run;
    int     tests_failed;

    gb_io_top UUT (
        .clk_cpu      (clk_cpu),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_do       (cpu_do),
        .cpu_wr       (cpu_wr),
        .cpu_rd       (cpu_rd),
        .irq_ack      (irq_ack),
        .vblank_evt   (vblank_evt),
        .lcd_evt      (lcd_evt),
        .timer_evt    (timer_evt),
        .joy_din      (joy_din),
        .cpu_di       (cpu_di),
        .irq_n        (irq_n),
        .joy_p54      (joy_p54),
        .sc_int_clock (sc_int_clock)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #50 clk_cpu = ~clk_cpu;   // 100 ns
    end

    // ----------------------------------------
    // bookkeeping and compares
    // ----------------------------------------
    task bump_error();
        errors++;
        test_errs++;
    endtask

    task check_byte(input string name, input gb_map_pkg::data_t got,
                    input gb_map_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            bump_error();
        end
    endtask

    task check_bit(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            bump_error();
        end
    endtask

    task end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ----------------------------------------
    // bus cycles
    // ----------------------------------------
    task bus_write(input gb_map_pkg::addr_t a, input gb_map_pkg::data_t d);
        @(posedge clk_cpu);
        cpu_addr <= a;
        cpu_do   <= d;
        cpu_wr   <= 1'b1;
        @(posedge clk_cpu);   // write taken here
        cpu_wr   <= 1'b0;
    endtask

    task bus_read(input gb_map_pkg::addr_t a, output gb_map_pkg::data_t d);
        @(posedge clk_cpu);
        cpu_addr <= a;
        cpu_rd   <= 1'b1;
        @(posedge clk_cpu);
        cpu_rd   <= 1'b0;
        @(negedge clk_cpu);   // cpu_di settled mid cycle
        d = cpu_di;
    endtask

    task ack_cycle(output gb_map_pkg::data_t vec);
        @(posedge clk_cpu);
        irq_ack <= 1'b1;
        repeat (2) @(posedge clk_cpu);
        irq_ack <= 1'b0;      // clear lands on the next edge
        @(negedge clk_cpu);
        vec = cpu_di;
    endtask

    task pulse_events(input logic [2:0] evt);   // {timer, lcd, vblank}
        @(posedge clk_cpu);
        vblank_evt <= evt[0];
        lcd_evt    <= evt[1];
        timer_evt  <= evt[2];
        @(posedge clk_cpu);
        vblank_evt <= 1'b0;
        lcd_evt    <= 1'b0;
        timer_evt  <= 1'b0;
    endtask

    task wait_irq_n(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk_cpu);
        while (irq_n !== level && n < limit) begin
            @(negedge clk_cpu);
            n++;
        end
        if (irq_n !== level) begin
            $display("irq_n did not go to %0d within %0d cycles", level, limit);
            bump_error();
        end
    endtask

    // repeated reads until the masked byte matches
    task poll_reg(input gb_map_pkg::addr_t a, input gb_map_pkg::data_t mask,
                  input gb_map_pkg::data_t value, input int limit);
        gb_map_pkg::data_t d;
        int                n;
        logic              ok;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            bus_read(a, d);
            ok = (d & mask) == value;
            n++;
        end
        if (!ok) begin
            $display("register %h never matched %h under mask %h in %0d reads",
                     a, value, mask, limit);
            bump_error();
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task test_ram();
        gb_map_pkg::data_t d0, d1, d2, d3, d4;
        gb_map_pkg::data_t got;
        d0 = 8'($random(seed));
        d1 = 8'($random(seed));
        d2 = 8'($random(seed));
        d3 = 8'($random(seed));
        d4 = 8'($random(seed));
        bus_write(16'hc010, d0);
        bus_write(16'hdff0, d1);   // above the echoed range
        bus_write(16'hff80, d2);
        bus_write(16'hfffe, d3);   // last hram byte
        bus_write(16'hfd00, d4);   // through the echo
        bus_write(16'h8000, 8'h00);   // unmapped, dropped
        bus_read(16'hc010, got);
        check_byte("wram c010", got, d0);
        bus_read(16'hdff0, got);
        check_byte("wram dff0", got, d1);
        bus_read(16'hff80, got);
        check_byte("hram ff80", got, d2);
        bus_read(16'hfffe, got);
        check_byte("hram fffe", got, d3);
        bus_read(16'he010, got);
        check_byte("echo e010", got, d0);
        bus_read(16'hdd00, got);
        check_byte("wram dd00", got, d4);
        bus_read(16'h8000, got);
        check_byte("open bus 8000", got, 8'hff);
        end_test("ram");
    endtask

    task test_joypad();
        gb_map_pkg::data_t got;
        check_bit("joy_p54", joy_p54, 2'b11);   // reset value
        @(posedge clk_cpu);
        joy_din <= 4'ha;
        bus_write(16'hff00, 8'h10);   // select 01
        @(negedge clk_cpu);
        check_bit("joy_p54", joy_p54, 2'b01);
        bus_read(16'hff00, got);
        check_byte("joy ff00", got, 8'hda);   // 11, 01, a
        @(posedge clk_cpu);
        joy_din <= 4'hf;   // rising lines only
        end_test("joypad register");
    endtask

    task test_irq_regs();
        gb_map_pkg::data_t got;
        bus_write(16'hffff, 8'h1f);
        bus_write(16'hff0f, 8'h00);
        wait_irq_n(1'b1, 8);
        pulse_events(3'b100);   // timer
        bus_read(16'hff0f, got);
        check_byte("if", got, 8'he4);
        wait_irq_n(1'b0, 8);
        ack_cycle(got);
        check_byte("irq_vec", got, 8'h50);   // timer vector
        bus_read(16'hff0f, got);
        check_byte("if", got, 8'he0);
        wait_irq_n(1'b1, 8);
        end_test("interrupt registers");
    endtask

    task test_priority();
        gb_map_pkg::data_t got;
        bus_write(16'hff0f, 8'h00);
        pulse_events(3'b011);   // lcd and vblank together
        wait_irq_n(1'b0, 8);
        ack_cycle(got);
        check_byte("irq_vec", got, 8'h40);   // vblank first
        ack_cycle(got);
        check_byte("irq_vec", got, 8'h48);   // then lcd
        bus_write(16'hffff, 8'h00);   // nothing enabled
        pulse_events(3'b010);
        ack_cycle(got);
        check_byte("irq_vec", got, 8'h55);
        repeat (4) begin
            @(negedge clk_cpu);
            check_bit("irq_n", {1'b0, irq_n}, 2'b01);
        end
        bus_read(16'hff0f, got);
        check_byte("if", got, 8'he2);   // idle ack clears nothing
        end_test("interrupt priority");
    endtask

    task test_serial();
        gb_map_pkg::data_t got;
        check_bit("sc_int_clock", {1'b0, sc_int_clock}, 2'b00);   // no sc write yet
        bus_write(16'hff0f, 8'h00);
        bus_write(16'hff01, 8'h3c);
        bus_write(16'hff02, 8'h81);   // start, internal clock
        @(negedge clk_cpu);
        check_bit("sc_int_clock", {1'b0, sc_int_clock}, 2'b01);
        poll_reg(16'hff02, 8'h80, 8'h00, serial_reads);
        bus_read(16'hff01, got);
        check_byte("sb", got, 8'hff);   // ones from the idle line
        bus_read(16'hff02, got);
        check_byte("sc", got, 8'h7f);
        bus_read(16'hff0f, got);
        check_byte("if", got, 8'he8);
        end_test("serial transfer");
    endtask

    task test_joy_irq();
        gb_map_pkg::data_t got;
        bus_write(16'hff0f, 8'h00);
        @(posedge clk_cpu);
        joy_din <= 4'b1110;   // line 0 pressed
        poll_reg(16'hff0f, 8'h10, 8'h10, 16);
        bus_read(16'hff0f, got);
        check_byte("if", got, 8'hf0);
        @(posedge clk_cpu);
        joy_din <= 4'hf;
        end_test("joypad interrupt");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        cpu_addr     = '0;
        cpu_do       = '0;
        cpu_wr       = 1'b0;
        cpu_rd       = 1'b0;
        irq_ack      = 1'b0;
        vblank_evt   = 1'b0;
        lcd_evt      = 1'b0;
        timer_evt    = 1'b0;
        joy_din      = 4'hf;   // nothing pressed
        repeat (10) @(posedge clk_cpu);
        reset <= 1'b0;
        @(posedge clk_cpu);
        test_ram();
        test_joypad();
        test_irq_regs();
        test_priority();
        test_serial();
        test_joy_irq();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_cpu);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: files.f
hdl/gb_map_pkg.sv
hdl/gb_io_pkg.sv
hdl/gb_spram.sv
hdl/gb_work_ram.sv
hdl/gb_joypad.sv
hdl/gb_serial.sv
hdl/gb_interrupts.sv
hdl/gb_cpu_bus.sv
hdl/gb_io_top.sv
tb/tb_gb_io.sv

// File: Bender.yml
package:
  name: gb_io

sources:
  # packages first
  - hdl/gb_map_pkg.sv
  - hdl/gb_io_pkg.sv
  # peripherals and bus
  - hdl/gb_spram.sv
  - hdl/gb_work_ram.sv
  - hdl/gb_joypad.sv
  - hdl/gb_serial.sv
  - hdl/gb_interrupts.sv
  - hdl/gb_cpu_bus.sv
  - hdl/gb_io_top.sv
  # testbench
  - target: test
    files:
      - tb/tb_gb_io.sv
